//--- filelist.f
+incdir+hw
hw/panel_pkg.sv
hw/pll_model.sv
hw/reset_sequencer.sv
hw/button_ctrl.sv
hw/spi_lcd_tx.sv
hw/panel_top.sv
testbench/tb_clock.sv
testbench/tb_panel_top.sv

//--- testbench/tb_panel_top.sv
`timescale 1ns/10ps
`include "board_defines.svh"

module tb_panel_top;

    import panel_pkg::*;

    typedef enum int {
        ACT_IDLE,
        ACT_BRIGHT,
        ACT_COLOR,
        ACT_BOTH,
        ACT_SOFT,
        ACT_BURST
    } act_t;

    localparam int NUM_ROWS       = 21;
    // cmd_valid to tx_done, 16 bits of two spi half periods plus start and tail
    localparam int FRAME_LEN      = 16 * 2 * `SPI_DIV + 2;
    localparam int RESET_BOUND    = 8 + `LOCK_DELAY + 2 + `RESET_HOLD + 8;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (FRAME_LEN + 40) + RESET_BOUND;
    localparam int SETTLE         = 16;

    logic        ref_clk;
    logic        ff_reset;
    logic        r;
    logic        bright_push;
    logic        color_push;
    logic [7:0]  leds;
    logic        spi_clk;
    logic        spi_mosi;
    logic        spi_cs_n;
    logic        lcd_dc;
    logic        screen_power;
    logic        test_out;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    string row_name [NUM_ROWS] = '{
        "reset_state",
        "bright_1", "bright_2", "bright_3", "bright_4",
        "bright_5", "bright_6", "bright_7", "bright_8",
        "color_1", "color_2", "color_3", "color_4", "color_5", "color_6", "color_7",
        "screen_off", "screen_on", "burst", "soft_reset", "bright_after_reset"
    };

    act_t row_act [NUM_ROWS] = '{
        ACT_IDLE,
        ACT_BRIGHT, ACT_BRIGHT, ACT_BRIGHT, ACT_BRIGHT,
        ACT_BRIGHT, ACT_BRIGHT, ACT_BRIGHT, ACT_BRIGHT,
        ACT_COLOR, ACT_COLOR, ACT_COLOR, ACT_COLOR, ACT_COLOR, ACT_COLOR, ACT_COLOR,
        ACT_BOTH, ACT_BOTH, ACT_BURST, ACT_SOFT, ACT_BRIGHT
    };

    // expected columns, filled from the panel model before the run
    lcd_cmd_t    row_cmd    [NUM_ROWS];
    lcd_cmd_t    row_first  [NUM_ROWS];
    led_status_t row_leds   [NUM_ROWS];
    int          row_frames [NUM_ROWS];

    // panel model state
    logic [7:0]  m_bright;
    int          m_color;
    logic        m_screen;

    // frame capture
    lcd_cmd_t    frame_q [$];
    logic [15:0] dc_q [$];
    logic [15:0] cap_data;
    logic [15:0] cap_dc;
    int          cap_bits;
    logic        frame_open = 1'b0;
    int          partial_cnt = 0;
    int          done_cnt = 0;

    integer      seed;
    int          err_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          cycle_cnt = 0;

    tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(8)) u_clock (
        .clk      (ref_clk),
        .ff_reset (ff_reset)
    );

    panel_top dut0 (
        .ref_clk      (ref_clk),
        .ff_reset     (ff_reset),
        .r            (r),
        .bright_push  (bright_push),
        .color_push   (color_push),
        .leds         (leds),
        .spi_clk      (spi_clk),
        .spi_mosi     (spi_mosi),
        .spi_cs_n     (spi_cs_n),
        .lcd_dc       (lcd_dc),
        .screen_power (screen_power),
        .test_out     (test_out)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // panel model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic void reset_model();
        m_bright = 8'(`RESET_BRIGHT);
        m_color  = 0;
        m_screen = 1'b1;
    endfunction

    // one press, returns the lcd command it should produce
    function automatic lcd_cmd_t step_model(input act_t act);
        lcd_cmd_t c;
        c.opcode  = OP_BRIGHT;
        c.payload = 8'h00;
        case (act)
            ACT_BRIGHT: begin
                m_bright  = 8'((m_bright + `BRIGHT_STEP) % 256);
                c.payload = m_bright;
            end
            ACT_COLOR: begin
                m_color   = (m_color + 1) % `COLOR_COUNT;
                c.opcode  = OP_COLOR;
                c.payload = 8'(m_color);
            end
            default: begin
                // both buttons, power toggles and payload stays zero
                m_screen = !m_screen;
                c.opcode = m_screen ? OP_DISP_ON : OP_DISP_OFF;
            end
        endcase
        return c;
    endfunction

    function automatic led_status_t expected_leds();
        led_status_t s;
        s.screen_on = m_screen;
        s.color     = 3'(m_color);
        s.bright_hi = m_bright[7:4];
        return s;
    endfunction

    function automatic void build_table();
        reset_model();
        for (int i = 0; i < NUM_ROWS; i++) begin
            row_frames[i] = 1;
            row_first[i]  = '0;
            row_cmd[i]    = '0;
            case (row_act[i])
                ACT_IDLE: begin
                    row_frames[i] = 0;
                end
                ACT_SOFT: begin
                    // the frame of this press gets cut off by the reset
                    row_cmd[i]    = step_model(ACT_BRIGHT);
                    row_frames[i] = 0;
                    reset_model();
                end
                ACT_BURST: begin
                    row_first[i]  = step_model(ACT_BRIGHT);
                    row_cmd[i]    = step_model(ACT_BRIGHT);
                    // only the newest pending command survives
                    row_cmd[i]    = step_model(ACT_BRIGHT);
                    row_frames[i] = 2;
                end
                default: begin
                    row_cmd[i] = step_model(row_act[i]);
                end
            endcase
            row_leds[i] = expected_leds();
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // spi frame capture
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge spi_cs_n) begin
        frame_open = 1'b1;
        cap_bits   = 0;
    end

    // mosi and lcd_dc are stable at the rising spi clock
    always @(posedge spi_clk) begin
        if (spi_cs_n === 1'b0) begin
            cap_data = {cap_data[14:0], spi_mosi};
            cap_dc   = {cap_dc[14:0], lcd_dc};
            cap_bits++;
        end
    end

    // a frame closed early counts as cut off
    always @(posedge spi_cs_n) begin
        if (frame_open) begin
            if (cap_bits == 16) begin
                frame_q.push_back(lcd_cmd_t'(cap_data));
                dc_q.push_back(cap_dc);
            end else begin
                partial_cnt++;
            end
        end
        frame_open = 1'b0;
    end

    always @(posedge test_out) begin
        done_cnt++;
    end

    // watchdog
    always @(posedge ref_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run stopped, no result after %0d cycles", cycle_cnt);
            $display("Checks failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_cmd(input string name, input lcd_cmd_t exp, input lcd_cmd_t act,
                             input logic [15:0] dc);
        logic [15:0] exp_bits;
        logic [15:0] act_bits;
        exp_bits = exp;
        act_bits = act;
        if (act_bits !== exp_bits) begin
            err_cnt++;
            $display("ERR %s: frame expected %h actual %h", name, exp_bits, act_bits);
        end
        // opcode bits with lcd_dc low, payload bits with lcd_dc high
        if (dc !== 16'h00FF) begin
            err_cnt++;
            $display("ERR %s: lcd_dc per bit expected %h actual %h", name, 16'h00FF, dc);
        end
    endtask

    task automatic check_leds(input string name, input led_status_t exp, input led_status_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s: leds expected %h actual %h", name, 8'(exp), 8'(act));
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s: %s expected %b actual %b", name, what, exp, act);
        end
    endtask

    task automatic report_problem(input string name, input string msg);
        err_cnt++;
        $display("%s: %s", name, msg);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // buttons are active low, hold time is random
    task automatic press_buttons(input logic use_bright, input logic use_color);
        int hold;
        hold = 2 + ($unsigned($random(seed)) % 8);
        @(negedge ref_clk);
        bright_push = !use_bright;
        color_push  = !use_color;
        repeat (hold) @(negedge ref_clk);
        bright_push = 1'b1;
        color_push  = 1'b1;
        repeat (3) @(negedge ref_clk);
    endtask

    task automatic wait_core(input logic level, input int limit, output bit ok);
        int n;
        n = 0;
        while (dut0.core_rst_n !== level && n < limit) begin
            @(negedge ref_clk);
            n++;
        end
        ok = (dut0.core_rst_n === level);
    endtask

    task automatic wait_frames(input int count, input int limit);
        int n;
        n = 0;
        while (frame_q.size() < count && n < limit) begin
            @(negedge ref_clk);
            n++;
        end
    endtask

    // r is pulled up, the rising edge after a low pulse resets the core
    task automatic pulse_soft_reset(input string name);
        bit ok;
        int n;
        n = 0;
        while (spi_cs_n !== 1'b0 && n < 20) begin
            @(negedge ref_clk);
            n++;
        end
        if (spi_cs_n !== 1'b0) begin
            report_problem(name, "no frame started before the soft reset");
        end
        // land the edge inside the opcode byte
        repeat (24) @(negedge ref_clk);
        r = 1'b0;
        repeat (2) @(negedge ref_clk);
        r = 1'b1;
        wait_core(1'b0, 4, ok);
        if (!ok) begin
            report_problem(name, "core did not enter reset on the r edge");
        end
        wait_core(1'b1, `RESET_HOLD + 8, ok);
        if (!ok) begin
            report_problem(name, "core did not leave reset after the r pulse");
        end
    endtask

    task automatic run_row(input int i);
        int done_base;
        int part_base;
        int exp_part;
        done_base = done_cnt;
        part_base = partial_cnt;
        exp_part  = (row_act[i] == ACT_SOFT) ? 1 : 0;
        frame_q.delete();
        dc_q.delete();
        case (row_act[i])
            ACT_IDLE:   repeat (40) @(negedge ref_clk);
            ACT_BRIGHT: press_buttons(1'b1, 1'b0);
            ACT_COLOR:  press_buttons(1'b0, 1'b1);
            ACT_BOTH:   press_buttons(1'b1, 1'b1);
            ACT_BURST:  repeat (3) press_buttons(1'b1, 1'b0);
            default: begin
                press_buttons(1'b1, 1'b0);
                pulse_soft_reset(row_name[i]);
            end
        endcase
        wait_frames(row_frames[i], row_frames[i] * (FRAME_LEN + 40));
        repeat (SETTLE) @(negedge ref_clk);
        if (frame_q.size() < row_frames[i]) begin
            report_problem(row_name[i], $sformatf("expected %0d frame(s) but only %0d arrived",
                row_frames[i], frame_q.size()));
        end else if (frame_q.size() > row_frames[i]) begin
            report_problem(row_name[i], $sformatf("expected %0d frame(s) but %0d arrived",
                row_frames[i], frame_q.size()));
        end else if (row_frames[i] == 2) begin
            check_cmd(row_name[i], row_first[i], frame_q[0], dc_q[0]);
            check_cmd(row_name[i], row_cmd[i], frame_q[1], dc_q[1]);
        end else if (row_frames[i] == 1) begin
            check_cmd(row_name[i], row_cmd[i], frame_q[0], dc_q[0]);
        end
        if (done_cnt - done_base != row_frames[i]) begin
            report_problem(row_name[i], $sformatf("test_out pulsed %0d times for %0d frame(s)",
                done_cnt - done_base, row_frames[i]));
        end
        if (partial_cnt - part_base != exp_part) begin
            report_problem(row_name[i], $sformatf("%0d frame(s) cut short where %0d expected",
                partial_cnt - part_base, exp_part));
        end
        check_leds(row_name[i], row_leds[i], leds);
        check_bit(row_name[i], "screen_power", row_leds[i].screen_on, screen_power);
        // nothing left running once the row is over
        check_bit(row_name[i], "spi_cs_n", 1'b1, spi_cs_n);
        check_bit(row_name[i], "test_out", 1'b0, test_out);
    endtask

    initial begin
        bit ok;
        int errs_before;
        bright_push = 1'b1;
        color_push  = 1'b1;
        r           = 1'b1;
        seed        = 26;
        build_table();
        wait_core(1'b1, RESET_BOUND, ok);
        if (!ok) begin
            report_problem("startup", "core reset was never released");
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            errs_before = err_cnt;
            run_row(i);
            if (err_cnt == errs_before) begin
                pass_cnt++;
                $display("PASS  %s", row_name[i]);
            end else begin
                fail_cnt++;
                $display("FAIL  %s", row_name[i]);
            end
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
            NUM_ROWS, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic ff_reset
);

    // free running reference clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // board reset low for the first cycles, released on a falling edge
    initial begin
        ff_reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        ff_reset = 1'b1;
    end

endmodule

//--- hw/panel_top.sv
`timescale 1ns/10ps

module panel_top (
    input  logic       ref_clk,
    input  logic       ff_reset,
    // soft reset pin, pulled up on the board
    input  logic       r,
    input  logic       bright_push,
    input  logic       color_push,
    output logic [7:0] leds,
    output logic       spi_clk,
    output logic       spi_mosi,
    output logic       spi_cs_n,
    output logic       lcd_dc,
    output logic       screen_power,
    output logic       test_out
);

    import panel_pkg::*;

    logic        pll_clk;
    logic        lock_async;
    logic        core_rst_n;
    lcd_cmd_t    cmd;
    logic        cmd_valid;
    logic        tx_busy;
    led_status_t status;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clock and reset
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    pll_model u_pll (
        .ref_clk (ref_clk),
        .rst_n   (ff_reset),
        .pll_clk (pll_clk),
        .lock    (lock_async)
    );

    reset_sequencer u_rst_seq (
        .pll_clk    (pll_clk),
        .ff_reset   (ff_reset),
        .lock_async (lock_async),
        .r          (r),
        .core_rst_n (core_rst_n)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // panel core
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    button_ctrl u_buttons (
        .pll_clk      (pll_clk),
        .core_rst_n   (core_rst_n),
        .bright_push  (bright_push),
        .color_push   (color_push),
        .tx_busy      (tx_busy),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .status       (status),
        .screen_power (screen_power)
    );

    // frame done pulse doubles as the board test point
    spi_lcd_tx u_spi_tx (
        .pll_clk    (pll_clk),
        .core_rst_n (core_rst_n),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .tx_busy    (tx_busy),
        .tx_done    (test_out),
        .spi_clk    (spi_clk),
        .spi_mosi   (spi_mosi),
        .spi_cs_n   (spi_cs_n),
        .lcd_dc     (lcd_dc)
    );

    assign leds = status;

endmodule

//--- hw/spi_lcd_tx.sv
`timescale 1ns/10ps
`include "board_defines.svh"

module spi_lcd_tx (
    input  logic                pll_clk,
    input  logic                core_rst_n,
    input  panel_pkg::lcd_cmd_t cmd,
    input  logic                cmd_valid,
    output logic                tx_busy,
    output logic                tx_done,
    output logic                spi_clk,
    output logic                spi_mosi,
    output logic                spi_cs_n,
    output logic                lcd_dc
);

    localparam int DIV_W = ($clog2(`SPI_DIV) > 0) ? $clog2(`SPI_DIV) : 1;
    localparam logic [DIV_W-1:0] LAST_DIV = DIV_W'(`SPI_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       bit_cnt;
    logic [15:0]      tx_shift;
    logic             tail;
    logic             bit_end;

    // last cycle of a bit, high half of spi_clk done
    assign bit_end = tx_busy && !tail && spi_clk && (div_cnt == LAST_DIV);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge pll_clk) begin
        if (!core_rst_n) begin
            tx_busy  <= 1'b0;
            tx_done  <= 1'b0;
            tail     <= 1'b0;
            spi_clk  <= 1'b0;
            spi_cs_n <= 1'b1;
            lcd_dc   <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
        end else begin
            tx_done <= 1'b0;
            if (!tx_busy) begin
                // start of frame, opcode byte goes out with lcd_dc low
                if (cmd_valid) begin
                    tx_busy  <= 1'b1;
                    spi_cs_n <= 1'b0;
                    lcd_dc   <= 1'b0;
                    div_cnt  <= '0;
                    bit_cnt  <= 4'd15;
                end
            end else if (tail) begin
                // one idle cycle after the last bit, then close the frame
                tail     <= 1'b0;
                tx_busy  <= 1'b0;
                tx_done  <= 1'b1;
                spi_cs_n <= 1'b1;
                lcd_dc   <= 1'b0;
            end else if (div_cnt == LAST_DIV) begin
                div_cnt <= '0;
                spi_clk <= ~spi_clk;
                if (spi_clk) begin
                    if (bit_cnt == 4'd0) begin
                        tail <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                    // payload byte starts at bit 7
                    if (bit_cnt == 4'd8) begin
                        lcd_dc <= 1'b1;
                    end
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // msb first, next bit presented while spi_clk is low
    always_ff @(posedge pll_clk) begin
        if (!tx_busy && cmd_valid) begin
            tx_shift <= cmd;
        end else if (bit_end) begin
            tx_shift <= {tx_shift[14:0], 1'b0};
        end
    end

    assign spi_mosi = tx_shift[15];

    // chip select covers the whole busy period
    a_cs_frame: assert property (@(posedge pll_clk) disable iff (!core_rst_n)
        tx_busy |-> !spi_cs_n);

endmodule

//--- hw/button_ctrl.sv
`timescale 1ns/10ps
`include "board_defines.svh"

module button_ctrl (
    input  logic                   pll_clk,
    input  logic                   core_rst_n,
    input  logic                   bright_push,
    input  logic                   color_push,
    input  logic                   tx_busy,
    output panel_pkg::lcd_cmd_t    cmd,
    output logic                   cmd_valid,
    output panel_pkg::led_status_t status,
    output logic                   screen_power
);

    import panel_pkg::*;

    // bit 1 is bright, bit 0 is color, both active low
    logic [1:0] btn_meta;
    logic [1:0] btn_sync;
    logic [1:0] btn_prev;
    logic [1:0] press;
    logic [7:0] bright;
    logic [7:0] bright_next;
    logic [2:0] color;
    logic [2:0] color_next;
    logic       screen_on;
    logic       new_valid;
    lcd_cmd_t   new_cmd;
    lcd_cmd_t   pend_cmd;
    logic       pend_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // button sync and press detect
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge pll_clk) begin
        if (!core_rst_n) begin
            btn_meta <= 2'b11;
            btn_sync <= 2'b11;
            btn_prev <= 2'b11;
        end else begin
            btn_meta <= {bright_push, color_push};
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
        end
    end

    // press is a high to low step of the synced level
    assign press = btn_prev & ~btn_sync;

    assign bright_next = bright + 8'(`BRIGHT_STEP);
    assign color_next  = (color == 3'(`COLOR_COUNT - 1)) ? 3'd0 : color + 3'd1;

    // command for this cycle's press, both buttons together toggle power
    always_comb begin
        new_valid = 1'b1;
        new_cmd   = '{opcode: OP_BRIGHT, payload: bright_next};
        if (press[1] && press[0]) begin
            new_cmd.opcode  = screen_on ? OP_DISP_OFF : OP_DISP_ON;
            new_cmd.payload = 8'h00;
        end else if (press[0]) begin
            new_cmd.opcode  = OP_COLOR;
            new_cmd.payload = {5'd0, color_next};
        end else if (!press[1]) begin
            new_valid = 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // panel state and pending command
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge pll_clk) begin
        if (!core_rst_n) begin
            bright     <= 8'(`RESET_BRIGHT);
            color      <= 3'd0;
            screen_on  <= 1'b1;
            pend_valid <= 1'b0;
            cmd_valid  <= 1'b0;
        end else begin
            if (press[1] && press[0]) begin
                screen_on <= ~screen_on;
            end else if (press[1]) begin
                bright <= bright_next;
            end else if (press[0]) begin
                color <= color_next;
            end
            // issue when the transmitter is idle, one strobe per command
            // a command landing in the slot this cycle goes out one cycle later
            cmd_valid <= pend_valid && !tx_busy && !cmd_valid && !new_valid;
            // a fresh command wins over the clear on issue
            if (new_valid) begin
                pend_valid <= 1'b1;
            end else if (pend_valid && !tx_busy && !cmd_valid) begin
                pend_valid <= 1'b0;
            end
        end
    end

    // newest command overwrites whatever is still waiting
    always_ff @(posedge pll_clk) begin
        if (new_valid) begin
            pend_cmd <= new_cmd;
        end
    end

    assign cmd          = pend_cmd;
    assign screen_power = screen_on;
    assign status       = '{screen_on: screen_on, color: color, bright_hi: bright[7:4]};

    // a new command only starts while the transmitter is idle
    a_no_issue_busy: assert property (@(posedge pll_clk) disable iff (!core_rst_n)
        $rose(cmd_valid) |-> !tx_busy);

endmodule

//--- hw/reset_sequencer.sv
`timescale 1ns/10ps
`include "board_defines.svh"

module reset_sequencer (
    input  logic pll_clk,
    input  logic ff_reset,
    input  logic lock_async,
    input  logic r,
    output logic core_rst_n
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lock synchronizer and soft reset edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic       lock_meta;
    logic       lock_sync;
    logic       r_q;
    logic       r_rise;
    logic       hold_clr;
    logic [3:0] hold_cnt;

    always_ff @(posedge pll_clk) begin
        if (!ff_reset) begin
            lock_meta <= 1'b0;
            lock_sync <= 1'b0;
            // pin is pulled up, idle level is high
            r_q       <= 1'b1;
        end else begin
            lock_meta <= lock_async;
            lock_sync <= lock_meta;
            r_q       <= r;
        end
    end

    // rising edge of the soft reset pin
    assign r_rise = r & ~r_q;

    // any of these restarts the whole hold period
    assign hold_clr = !ff_reset || !lock_sync || r_rise;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hold counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge pll_clk) begin
        if (hold_clr) begin
            hold_cnt   <= '0;
            core_rst_n <= 1'b0;
        end else begin
            // count locked cycles, saturate at the hold value
            if (hold_cnt != 4'(`RESET_HOLD)) begin
                hold_cnt <= hold_cnt + 1'b1;
            end
            // release once the full hold count has been seen
            core_rst_n <= (hold_cnt == 4'(`RESET_HOLD));
        end
    end

    // a soft reset edge always puts the core back into reset
    a_soft_reset: assert property (@(posedge pll_clk) disable iff (!ff_reset)
        r_rise |=> !core_rst_n);

    // core stays in reset for the full hold count after lock returns
    a_hold_len: assert property (@(posedge pll_clk) disable iff (!ff_reset)
        $rose(lock_sync) |-> !core_rst_n [*`RESET_HOLD]);

endmodule

//--- hw/pll_model.sv
`timescale 1ns/10ps
`include "board_defines.svh"

module pll_model (
    input  logic ref_clk,
    input  logic rst_n,
    output logic pll_clk,
    output logic lock
);

    // counter wide enough to reach LOCK_DELAY
    localparam int CNT_W = $clog2(`LOCK_DELAY + 1);

    logic [CNT_W-1:0] lock_cnt;

    // no multiplication in this model, output follows the reference
    assign pll_clk = ref_clk;

    // lock rises after LOCK_DELAY reference cycles out of reset
    always_ff @(posedge ref_clk) begin
        if (!rst_n) begin
            lock_cnt <= '0;
            lock     <= 1'b0;
        end else if (lock_cnt == CNT_W'(`LOCK_DELAY - 1)) begin
            lock <= 1'b1;
        end else begin
            lock_cnt <= lock_cnt + 1'b1;
        end
    end

    // once locked, lock holds until the next reset
    a_lock_sticky: assert property (@(posedge ref_clk) disable iff (!rst_n)
        lock |=> lock);

endmodule

//--- hw/panel_pkg.sv
package panel_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lcd command set
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // opcodes sent as the first byte of a frame, with lcd_dc low
    typedef enum logic [7:0] {
        // write display brightness
        OP_BRIGHT   = 8'h51,
        // select color preset
        OP_COLOR    = 8'hC0,
        OP_DISP_ON  = 8'h29,
        OP_DISP_OFF = 8'h28
    } lcd_op_t;

    // one spi frame, opcode byte first then payload byte
    typedef struct packed {
        lcd_op_t    opcode;
        logic [7:0] payload;
    } lcd_cmd_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // led view of the panel state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // maps straight onto leds[7:0]
    typedef struct packed {
        // leds[7]
        logic       screen_on;
        // leds[6:4]
        logic [2:0] color;
        // leds[3:0], top nibble of brightness
        logic [3:0] bright_hi;
    } led_status_t;

endpackage

//--- hw/board_defines.svh
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// panel button constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// brightness added per bright press, wraps at 256
`define BRIGHT_STEP 16
// number of color presets, index runs 0..COLOR_COUNT-1
`define COLOR_COUNT 6
// brightness level after reset
`define RESET_BRIGHT 128

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// pll_clk cycles per spi clock half period
`define SPI_DIV 4
// reference cycles until the pll model reports lock
`define LOCK_DELAY 20
// locked cycles before the core leaves reset
`define RESET_HOLD 15

`endif
